// ==== src/ids_macros.svh ====
`ifndef IDS_MACROS_SVH
`define IDS_MACROS_SVH

// Clocking and UART bit timing
`define IDS_CLOCK_FREQ      1_843_200
`define IDS_BAUD_RATE       115_200
`define IDS_CLKS_PER_BIT    (`IDS_CLOCK_FREQ / `IDS_BAUD_RATE)

// SRAM windows
`define IDS_IMEM_BASE       32'h4000_0000
`define IDS_DMEM_BASE       32'h4001_0000
`define IDS_BUF_BASE        32'h4002_0000

// Depths in 32-bit words
`define IDS_IMEM_DEPTH      1024
`define IDS_DMEM_DEPTH      1024
`define IDS_BUF_DEPTH       8192

// UART registers
`define IDS_UART_CTRL       32'h8000_0000
`define IDS_UART_TRANS      32'h8000_0008

// SPI frame layout
`define IDS_SPI_CMD_BITS    8
`define IDS_SPI_ADDR_BITS   32
`define IDS_SPI_DATA_BITS   32

`endif

// ==== src/ids_pkg.sv ====
package ids_pkg;

    // Byte address on the internal bus
    typedef logic [31:0] bus_addr_t;

    // One bus data word
    typedef logic [31:0] bus_data_t;

    // Byte enables, bit n covers bits 8n+7..8n
    typedef logic [3:0] bus_strb_t;

    // Access targets
    typedef enum logic [2:0] {
        SEL_IMEM,
        SEL_DMEM,
        SEL_BUF,
        SEL_UART,
        SEL_NONE
    } slave_sel_t;

endpackage

// ==== src/spi_bus_master.sv ====
`timescale 1ns/1ns
`include "ids_macros.svh"

module spi_bus_master (
    input  logic                i_clk,
    input  logic                i_rst_n,
    // SPI pins
    input  logic                i_sclk,
    input  logic                i_cs,
    input  logic                i_mosi,
    output logic                o_miso,
    // Bus side
    input  ids_pkg::bus_data_t  i_rdata,
    output logic                o_bus_stb,
    output logic                o_bus_we,
    output ids_pkg::bus_addr_t  o_bus_addr,
    output ids_pkg::bus_data_t  o_bus_wdata,
    output ids_pkg::bus_strb_t  o_bus_strb
);
    import ids_pkg::*;

    localparam int CMD_END   = `IDS_SPI_CMD_BITS;
    localparam int ADDR_END  = CMD_END + `IDS_SPI_ADDR_BITS;
    localparam int FRAME_END = ADDR_END + `IDS_SPI_DATA_BITS;
    localparam int CNT_W     = $clog2(FRAME_END + 1);

    localparam logic [CNT_W-1:0] CNT_CMD_LAST   = CNT_W'(CMD_END - 1);
    localparam logic [CNT_W-1:0] CNT_ADDR_LAST  = CNT_W'(ADDR_END - 1);
    localparam logic [CNT_W-1:0] CNT_ADDR_END   = CNT_W'(ADDR_END);
    localparam logic [CNT_W-1:0] CNT_FRAME_LAST = CNT_W'(FRAME_END - 1);
    localparam logic [CNT_W-1:0] CNT_FRAME_END  = CNT_W'(FRAME_END);

    logic [2:0]       sclk_sync;
    logic [1:0]       cs_sync;
    logic [1:0]       mosi_sync;
    logic             sclk_rise;
    logic             sclk_fall;
    logic             cs_n;
    logic             mosi;
    logic [CNT_W-1:0] bit_cnt;
    bus_data_t        shift_in;
    bus_data_t        shift_next;
    logic             rd_pend;
    logic             miso_en;
    bus_data_t        miso_shift;

    // Two-flop synchronizers, sclk gets a third stage for edge detect
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sclk_sync <= 3'b000;
            cs_sync   <= 2'b11;
            mosi_sync <= 2'b00;
        end else begin
            sclk_sync <= {sclk_sync[1:0], i_sclk};
            cs_sync   <= {cs_sync[0], i_cs};
            mosi_sync <= {mosi_sync[0], i_mosi};
        end
    end

    assign sclk_rise  = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall  = ~sclk_sync[1] & sclk_sync[2];
    assign cs_n       = cs_sync[1];
    assign mosi       = mosi_sync[1];
    assign shift_next = {shift_in[30:0], mosi};

    // Bit counter and bus strobe
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            bit_cnt   <= '0;
            o_bus_stb <= 1'b0;
            o_bus_we  <= 1'b0;
            rd_pend   <= 1'b0;
        end else begin
            o_bus_stb <= 1'b0;
            rd_pend   <= o_bus_stb & ~o_bus_we;
            if (cs_n) begin
                bit_cnt <= '0;
            end else if (sclk_rise && bit_cnt != CNT_FRAME_END) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_CMD_LAST) begin
                    o_bus_we <= shift_next[7];
                end
                // Reads go out once the address is in
                if (bit_cnt == CNT_ADDR_LAST && !o_bus_we) begin
                    o_bus_stb <= 1'b1;
                end
                if (bit_cnt == CNT_FRAME_LAST && o_bus_we) begin
                    o_bus_stb <= 1'b1;
                end
            end
        end
    end

    // Frame fields
    always_ff @(posedge i_clk) begin
        if (!cs_n && sclk_rise && bit_cnt != CNT_FRAME_END) begin
            shift_in <= shift_next;
            if (bit_cnt == CNT_CMD_LAST) begin
                o_bus_strb <= shift_next[3:0];
            end
            if (bit_cnt == CNT_ADDR_LAST) begin
                o_bus_addr <= shift_next;
            end
            if (bit_cnt == CNT_FRAME_LAST) begin
                o_bus_wdata <= shift_next;
            end
        end
    end

    // MISO enable covers the read data phase only
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            miso_en <= 1'b0;
        end else if (cs_n) begin
            miso_en <= 1'b0;
        end else if (rd_pend) begin
            miso_en <= 1'b1;
        end else if (sclk_rise && bit_cnt == CNT_FRAME_LAST) begin
            miso_en <= 1'b0;
        end
    end

    // No shift on the falling edge ahead of the first data bit
    always_ff @(posedge i_clk) begin
        if (rd_pend) begin
            miso_shift <= i_rdata;
        end else if (sclk_fall && bit_cnt > CNT_ADDR_END) begin
            miso_shift <= {miso_shift[30:0], 1'b0};
        end
    end

    assign o_miso = miso_en & miso_shift[31];

endmodule

// ==== src/bus_decoder.sv ====
`timescale 1ns/1ns
`include "ids_macros.svh"

module bus_decoder (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_bus_stb,
    input  ids_pkg::bus_addr_t  i_bus_addr,
    input  ids_pkg::bus_data_t  i_imem_rdata,
    input  ids_pkg::bus_data_t  i_dmem_rdata,
    input  ids_pkg::bus_data_t  i_buf_rdata,
    input  ids_pkg::bus_data_t  i_uart_rdata,
    output logic                o_imem_stb,
    output logic                o_dmem_stb,
    output logic                o_buf_stb,
    output logic                o_uart_stb,
    output ids_pkg::bus_data_t  o_rdata
);
    import ids_pkg::*;

    // Window ends, one past the last byte
    localparam bus_addr_t IMEM_END = `IDS_IMEM_BASE + 4 * `IDS_IMEM_DEPTH;
    localparam bus_addr_t DMEM_END = `IDS_DMEM_BASE + 4 * `IDS_DMEM_DEPTH;
    localparam bus_addr_t BUF_END  = `IDS_BUF_BASE + 4 * `IDS_BUF_DEPTH;

    slave_sel_t sel;
    slave_sel_t sel_q;

    always_comb begin
        if (i_bus_addr >= `IDS_IMEM_BASE && i_bus_addr < IMEM_END) begin
            sel = SEL_IMEM;
        end else if (i_bus_addr >= `IDS_DMEM_BASE && i_bus_addr < DMEM_END) begin
            sel = SEL_DMEM;
        end else if (i_bus_addr >= `IDS_BUF_BASE && i_bus_addr < BUF_END) begin
            sel = SEL_BUF;
        end else if (i_bus_addr == `IDS_UART_CTRL || i_bus_addr == `IDS_UART_TRANS) begin
            sel = SEL_UART;
        end else begin
            sel = SEL_NONE;
        end
    end

    assign o_imem_stb = i_bus_stb && (sel == SEL_IMEM);
    assign o_dmem_stb = i_bus_stb && (sel == SEL_DMEM);
    assign o_buf_stb  = i_bus_stb && (sel == SEL_BUF);
    assign o_uart_stb = i_bus_stb && (sel == SEL_UART);

    // Target of the last access, steers the return mux
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sel_q <= SEL_NONE;
        end else if (i_bus_stb) begin
            sel_q <= sel;
        end
    end

    always_comb begin
        case (sel_q)
            SEL_IMEM: o_rdata = i_imem_rdata;
            SEL_DMEM: o_rdata = i_dmem_rdata;
            SEL_BUF:  o_rdata = i_buf_rdata;
            SEL_UART: o_rdata = i_uart_rdata;
            default:  o_rdata = '0;
        endcase
    end

endmodule

// ==== src/sram_byte_we.sv ====
`timescale 1ns/1ns

module sram_byte_we #(
    parameter int DEPTH = 1024
) (
    input  logic                i_clk,
    input  logic                i_stb,
    input  logic                i_we,
    input  ids_pkg::bus_addr_t  i_addr,
    input  ids_pkg::bus_data_t  i_wdata,
    input  ids_pkg::bus_strb_t  i_strb,
    output ids_pkg::bus_data_t  o_rdata
);
    import ids_pkg::*;

    localparam int AW = $clog2(DEPTH);

    bus_data_t     mem [DEPTH];
    logic [AW-1:0] idx;

    // Word index wraps at DEPTH
    assign idx = i_addr[AW+1:2];

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            if (i_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_strb[b]) begin
                        mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];
                    end
                end
            end else begin
                o_rdata <= mem[idx];
            end
        end
    end

endmodule

// ==== src/uart_regs.sv ====
`timescale 1ns/1ns
`include "ids_macros.svh"

module uart_regs (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_stb,
    input  logic                i_we,
    input  ids_pkg::bus_addr_t  i_addr,
    input  ids_pkg::bus_data_t  i_wdata,
    output ids_pkg::bus_data_t  o_rdata,
    // Transmitter side
    input  logic                i_tx_busy,
    output logic                o_tx_start,
    output logic [7:0]          o_tx_byte
);
    import ids_pkg::*;

    logic      uart_en;
    logic      tx_accept;
    bus_data_t ctrl_word;

    // Busy in bit 1, enable in bit 0
    assign ctrl_word = {30'd0, i_tx_busy, uart_en};

    // Byte is dropped when disabled or a frame is still going
    assign tx_accept = i_stb && i_we && (i_addr == `IDS_UART_TRANS)
                       && uart_en && !i_tx_busy && !o_tx_start;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            uart_en    <= 1'b0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= tx_accept;
            if (i_stb && i_we && i_addr == `IDS_UART_CTRL) begin
                uart_en <= i_wdata[0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (tx_accept) begin
            o_tx_byte <= i_wdata[7:0];
        end
        if (i_stb && !i_we) begin
            o_rdata <= (i_addr == `IDS_UART_CTRL) ? ctrl_word : '0;
        end
    end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_tx_start,
    input  logic [7:0]  i_tx_byte,
    output logic        o_serial_tx,
    output logic        o_tx_busy
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);

    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;
    logic [9:0]    tx_shift;

    // Ones shift in behind the frame, so the line idles high
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_tx_busy <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            tx_shift  <= '1;
        end else if (!o_tx_busy) begin
            if (i_tx_start) begin
                // Stop, data LSB first, start
                tx_shift  <= {1'b1, i_tx_byte, 1'b0};
                o_tx_busy <= 1'b1;
                clk_cnt   <= '0;
                bit_idx   <= '0;
            end
        end else if (clk_cnt == BIT_LAST) begin
            clk_cnt  <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (bit_idx == 4'd9) begin
                o_tx_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    assign o_serial_tx = tx_shift[0];

endmodule

// ==== src/ids_soc_top.sv ====
`timescale 1ns/1ns
`include "ids_macros.svh"

module ids_soc_top (
    input  logic    i_clk,
    input  logic    i_rst_n,
    // SPI
    input  logic    i_sclk,
    input  logic    i_cs,
    input  logic    i_mosi,
    output logic    o_miso,
    // UART, receive pin has no logic behind it
    input  logic    i_serial_rx,
    output logic    o_serial_tx
);
    import ids_pkg::*;

    logic       bus_stb;
    logic       bus_we;
    bus_addr_t  bus_addr;
    bus_data_t  bus_wdata;
    bus_strb_t  bus_strb;
    bus_data_t  bus_rdata;

    logic       imem_stb;
    logic       dmem_stb;
    logic       buf_stb;
    logic       uart_stb;
    bus_data_t  imem_rdata;
    bus_data_t  dmem_rdata;
    bus_data_t  buf_rdata;
    bus_data_t  uart_rdata;

    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;

    spi_bus_master u_spi (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_sclk      (i_sclk),
        .i_cs        (i_cs),
        .i_mosi      (i_mosi),
        .o_miso      (o_miso),
        .i_rdata     (bus_rdata),
        .o_bus_stb   (bus_stb),
        .o_bus_we    (bus_we),
        .o_bus_addr  (bus_addr),
        .o_bus_wdata (bus_wdata),
        .o_bus_strb  (bus_strb)
    );

    bus_decoder u_dec (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_bus_stb    (bus_stb),
        .i_bus_addr   (bus_addr),
        .i_imem_rdata (imem_rdata),
        .i_dmem_rdata (dmem_rdata),
        .i_buf_rdata  (buf_rdata),
        .i_uart_rdata (uart_rdata),
        .o_imem_stb   (imem_stb),
        .o_dmem_stb   (dmem_stb),
        .o_buf_stb    (buf_stb),
        .o_uart_stb   (uart_stb),
        .o_rdata      (bus_rdata)
    );

    sram_byte_we #(.DEPTH(`IDS_IMEM_DEPTH)) u_imem (
        .i_clk   (i_clk),
        .i_stb   (imem_stb),
        .i_we    (bus_we),
        .i_addr  (bus_addr),
        .i_wdata (bus_wdata),
        .i_strb  (bus_strb),
        .o_rdata (imem_rdata)
    );

    sram_byte_we #(.DEPTH(`IDS_DMEM_DEPTH)) u_dmem (
        .i_clk   (i_clk),
        .i_stb   (dmem_stb),
        .i_we    (bus_we),
        .i_addr  (bus_addr),
        .i_wdata (bus_wdata),
        .i_strb  (bus_strb),
        .o_rdata (dmem_rdata)
    );

    // Weight and activation buffer
    sram_byte_we #(.DEPTH(`IDS_BUF_DEPTH)) u_buf (
        .i_clk   (i_clk),
        .i_stb   (buf_stb),
        .i_we    (bus_we),
        .i_addr  (bus_addr),
        .i_wdata (bus_wdata),
        .i_strb  (bus_strb),
        .o_rdata (buf_rdata)
    );

    uart_regs u_uart_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stb      (uart_stb),
        .i_we       (bus_we),
        .i_addr     (bus_addr),
        .i_wdata    (bus_wdata),
        .o_rdata    (uart_rdata),
        .i_tx_busy  (tx_busy),
        .o_tx_start (tx_start),
        .o_tx_byte  (tx_byte)
    );

    uart_tx #(.CLKS_PER_BIT(`IDS_CLKS_PER_BIT)) u_uart_tx (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tx_start  (tx_start),
        .i_tx_byte   (tx_byte),
        .o_serial_tx (o_serial_tx),
        .o_tx_busy   (tx_busy)
    );

endmodule

// ==== tb/tb_ids_soc.sv ====
`timescale 1ns/1ns
`include "ids_macros.svh"

module tb_ids_soc;

    localparam int HALF_SCLK  = 10;
    localparam int UART_FRAME = 10 * `IDS_CLKS_PER_BIT;
    localparam int N_FRAMES   = 49;
    // Frames of 72 bits at 20 clocks each, four UART frames, then doubled
    localparam int WATCHDOG_CLKS = 2 * (N_FRAMES * 72 * 2 * HALF_SCLK + 4 * UART_FRAME);

    logic clk;
    logic rst_n;
    logic sclk;
    logic cs;
    logic mosi;
    logic miso;
    logic serial_rx;
    logic serial_tx;

    integer      seed = 32'h8ce8_9d00;
    int          n_checks = 0;
    int          n_errors = 0;
    int          test_err_base = 0;
    logic [31:0] ref_mem [logic [31:0]];
    logic        ref_uart_en = 1'b0;
    logic [31:0] addr_q [$];
    string       tag_q [$];
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];
    logic [7:0]  rx_q [$];
    logic [7:0]  rx_byte;
    logic        busy_mid;
    string       cmp_tag;
    logic [31:0] cmp_got;
    logic [31:0] cmp_exp;

    ids_soc_top i_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_sclk      (sclk),
        .i_cs        (cs),
        .i_mosi      (mosi),
        .o_miso      (miso),
        .i_serial_rx (serial_rx),
        .o_serial_tx (serial_tx)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic mem_mapped(input logic [31:0] addr);
        return (addr >= `IDS_IMEM_BASE && addr < `IDS_IMEM_BASE + 4 * `IDS_IMEM_DEPTH)
            || (addr >= `IDS_DMEM_BASE && addr < `IDS_DMEM_BASE + 4 * `IDS_DMEM_DEPTH)
            || (addr >= `IDS_BUF_BASE && addr < `IDS_BUF_BASE + 4 * `IDS_BUF_DEPTH);
    endfunction

    // Busy reads as 0, UART_CTRL is only read while the transmitter is idle
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        if (addr == `IDS_UART_CTRL) begin
            return {31'd0, ref_uart_en};
        end
        if (mem_mapped(addr) && ref_mem.exists(addr & ~32'h3)) begin
            return ref_mem[addr & ~32'h3];
        end
        return 32'd0;
    endfunction

    function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
        logic [31:0] word;
        word = ref_read(addr);
        if (addr == `IDS_UART_CTRL) begin
            ref_uart_en = data[0];
        end
        if (mem_mapped(addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    word[8*b +: 8] = data[8*b +: 8];
                end
            end
            ref_mem[addr & ~32'h3] = word;
        end
    endfunction

    function automatic logic [31:0] random_addr(input int region);
        logic [31:0] word;
        word = $random(seed);
        case (region)
            0:       return `IDS_IMEM_BASE + ((word % `IDS_IMEM_DEPTH) << 2);
            1:       return `IDS_DMEM_BASE + ((word % `IDS_DMEM_DEPTH) << 2);
            default: return `IDS_BUF_BASE + ((word % `IDS_BUF_DEPTH) << 2);
        endcase
    endfunction

    function automatic void expect_value(input string tag, input logic [31:0] got,
                                         input logic [31:0] exp);
        tag_q.push_back(tag);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endfunction

    // Mode 0 frame, MOSI set while sclk is low, MISO taken at the rising edge
    task automatic spi_frame(input logic [7:0] cmd, input logic [31:0] addr,
                             input logic [31:0] wdata, input int nbits,
                             output logic [31:0] rdata);
        logic [71:0] tx_bits;
        tx_bits = {cmd, addr, wdata};
        rdata = 32'd0;
        cs = 1'b0;
        repeat (HALF_SCLK) @(negedge clk);
        for (int i = 0; i < nbits; i++) begin
            mosi = tx_bits[71 - i];
            repeat (HALF_SCLK) @(negedge clk);
            sclk = 1'b1;
            if (i >= 40) begin
                rdata = {rdata[30:0], miso};
            end
            repeat (HALF_SCLK) @(negedge clk);
            sclk = 1'b0;
        end
        mosi = 1'b0;
        repeat (HALF_SCLK) @(negedge clk);
        cs = 1'b1;
        repeat (2 * HALF_SCLK) @(negedge clk);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [31:0] ignored;
        spi_frame({1'b1, 3'b000, strb}, addr, data, 72, ignored);
        ref_write(addr, data, strb);
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] rd;
        spi_frame(8'h0F, addr, 32'd0, 72, rd);
        expect_value($sformatf("o_miso read of %h", addr), rd, ref_read(addr));
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
        if (n_errors == test_err_base) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, n_errors - test_err_base);
        end
        test_err_base = n_errors;
    endtask

    always @(posedge clk) begin
        while (exp_q.size() > 0) begin
            cmp_tag = tag_q.pop_front();
            cmp_got = got_q.pop_front();
            cmp_exp = exp_q.pop_front();
            n_checks++;
            assert (cmp_got === cmp_exp)
            else begin
                $display("Error at %0t ns: %s, got %h, expected %h",
                         $time, cmp_tag, cmp_got, cmp_exp);
                n_errors++;
            end
        end
    end

    // UART sampler, centre of each bit
    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(negedge serial_tx);
            repeat (`IDS_CLKS_PER_BIT / 2) @(negedge clk);
            busy_mid = i_dut.u_uart_regs.ctrl_word[1];
            expect_value("o_serial_tx start bit", {31'd0, serial_tx}, 32'd0);
            for (int b = 0; b < 8; b++) begin
                repeat (`IDS_CLKS_PER_BIT) @(negedge clk);
                rx_byte[b] = serial_tx;
            end
            repeat (`IDS_CLKS_PER_BIT) @(negedge clk);
            expect_value("o_serial_tx stop bit", {31'd0, serial_tx}, 32'd1);
            rx_q.push_back(rx_byte);
        end
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Watchdog expired after %0d clocks, the tests did not finish", WATCHDOG_CLKS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] rd;
        logic [7:0]  tx_val;
        int          waited;
        rst_n = 1'b0;
        sclk = 1'b0;
        cs = 1'b1;
        mosi = 1'b0;
        serial_rx = 1'b1;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        expect_value("o_serial_tx after reset", {31'd0, serial_tx}, 32'd1);
        expect_value("o_miso after reset", {31'd0, miso}, 32'd0);
        finish_test("reset state");

        // Four words each in IMEM, DMEM and BUF
        for (int r = 0; r < 3; r++) begin
            for (int n = 0; n < 4; n++) begin
                addr = random_addr(r);
                addr_q.push_back(addr);
                bus_write(addr, $random(seed), 4'hF);
            end
        end
        foreach (addr_q[i]) begin
            read_check(addr_q[i]);
        end
        finish_test("full word writes");

        bus_write(addr_q[1], $random(seed), 4'b0001);
        bus_write(addr_q[5], $random(seed), 4'b0110);
        bus_write(addr_q[9], $random(seed), 4'b1000);
        bus_write(addr_q[10], $random(seed), 4'b1010);
        read_check(addr_q[1]);
        read_check(addr_q[5]);
        read_check(addr_q[9]);
        read_check(addr_q[10]);
        finish_test("byte enable writes");

        // Just past IMEM and BUF, same low address bits as written words
        read_check(32'h0000_0000);
        read_check(32'hC000_0010);
        read_check(addr_q[0] + 32'h1000);
        bus_write(addr_q[0] + 32'h1000, $random(seed), 4'hF);
        bus_write(addr_q[8] + 32'h8000, $random(seed), 4'hF);
        read_check(addr_q[0]);
        read_check(addr_q[8]);
        finish_test("unmapped addresses");

        spi_frame(8'h8F, addr_q[4], ~ref_read(addr_q[4]), 40, rd);
        read_check(addr_q[4]);
        bus_write(addr_q[4], $random(seed), 4'hF);
        read_check(addr_q[4]);
        finish_test("abandoned frame");

        rd = $random(seed);
        tx_val = rd[7:0];
        bus_write(`IDS_UART_TRANS, {24'd0, tx_val}, 4'hF);
        repeat (2 * UART_FRAME) @(negedge clk);
        n_checks++;
        assert (rx_q.size() == 0)
        else begin
            $display("A UART frame appeared on o_serial_tx while the UART was disabled");
            n_errors++;
        end
        read_check(`IDS_UART_CTRL);
        bus_write(`IDS_UART_CTRL, 32'd1, 4'hF);
        read_check(`IDS_UART_CTRL);
        bus_write(`IDS_UART_TRANS, {24'd0, ~tx_val}, 4'hF);
        waited = 0;
        while (rx_q.size() == 0 && waited < 2 * UART_FRAME) begin
            @(negedge clk);
            waited++;
        end
        n_checks++;
        assert (rx_q.size() != 0)
        else begin
            $display("No UART frame arrived on o_serial_tx after the enabled write");
            n_errors++;
        end
        if (rx_q.size() != 0) begin
            expect_value("o_serial_tx data byte", {24'd0, rx_q.pop_front()}, {24'd0, ~tx_val});
            expect_value("UART_CTRL busy bit", {31'd0, busy_mid}, 32'd1);
        end
        read_check(`IDS_UART_CTRL);
        finish_test("UART transmit");

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== ids_soc.f ====
+incdir+src
src/ids_pkg.sv
src/spi_bus_master.sv
src/bus_decoder.sv
src/sram_byte_we.sv
src/uart_regs.sv
src/uart_tx.sv
src/ids_soc_top.sv
tb/tb_ids_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ids_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ids_soc -f ids_soc.f \
    --Mdir "$BUILD_DIR" -o tb_ids_soc
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_ids_soc" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG_FILE"; then
    exit 0
fi
exit 1
